// ==== tb.f ====
logic/memPkg.sv
logic/memIfc.sv
logic/memStageReg.sv
logic/memAccess.sv
logic/exceptionUnit.sv
logic/cp0Regs.sv
logic/memStage.sv
verif/memStageTb.sv

// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - files:
      - logic/memPkg.sv
      - logic/memIfc.sv
      - logic/memStageReg.sv
      - logic/memAccess.sv
      - logic/exceptionUnit.sv
      - logic/cp0Regs.sv
      - logic/memStage.sv
  - target: test
    files:
      - verif/memStageTb.sv

// ==== verif/memStageTb.sv ====
// memory stage testbench running a table of instructions against a reference model
`timescale 1ns/100ps

module memStageTb import memPkg::*; ();

    // one instruction as it arrives from execute plus the stage controls
    typedef struct packed {
        word_t      pc;
        word_t      alu;
        word_t      opB;
        regAddr_t   dst;
        regAddr_t   cp0Addr;
        logic       regWr;
        logic       isBranch;
        logic       inExcValid;
        logic [1:0] wbSel;
        logic [3:0] memOp;
        logic [1:0] cp0Op;
        excCode_t   inExc;
        logic       flush;
        logic       wr;
        logic       disWr;  // applied while the row sits in mem
        logic [5:0] irq;
    } stim_t;

    // top outputs packed in the order of the compare below
    typedef struct packed {
        word_t      pc;
        word_t      result;
        regAddr_t   dst;
        logic       regWr;
        logic       valid;
        logic       write;
        word_t      addr;
        word_t      wdata;
        logic [3:0] wstrb;
        logic       flush;
        logic [1:0] entry;
        word_t      vector;
        word_t      epc;
    } resp_t;

    localparam int clkPeriod   = 40;
    localparam int resetCycles = 3;

    logic       clk;
    logic       rstN;
    logic       memFlush;
    logic       memWr;
    logic       memDisWr;
    word_t      exePc;
    word_t      exeAluOut;
    word_t      exeOperandB;
    regAddr_t   exeDst;
    regAddr_t   exeCp0Addr;
    logic       exeRegWr;
    logic       exeIsBranch;
    logic       exeInExcValid;
    wbSel_t     exeWbSel;
    memOp_t     exeMemOp;
    cp0Op_t     exeCp0Op;
    excCode_t   exeInExc;
    logic [5:0] interrupt;
    word_t      memPc;
    word_t      memResult;
    regAddr_t   memDst;
    logic       memRegWr;
    logic       dbusValid;
    logic       dbusWrite;
    word_t      dbusAddr;
    word_t      dbusWdata;
    logic [3:0] dbusWstrb;
    logic       flushException;
    entrySel_t  entrySel;
    word_t      exceptionVector;
    word_t      epcOut;

    stim_t rows[$];
    resp_t expects[$];
    string names[$];

    int          passCount = 0;
    int          failCount = 0;
    logic        tableReady = 1'b0;
    logic [31:0] rngState = 32'd21410;
    word_t       nextPc;
    logic [5:0]  curIrq;

    // reference model state
    stim_t      held;        // instruction in mem
    logic       heldSlot;
    logic       lastBranch;
    logic       mBev, mExl, mIe, mBd;
    logic [7:0] mIm;
    logic [5:0] mIpHw;
    logic [1:0] mIpSw;
    excCode_t   mExc;
    word_t      mEpc, mBadVAddr;
    logic       takeExc, takeEret, doMtc0;
    excCode_t   takeCode;
    word_t      takeBad;

    memStage dut_i (
        .clk(clk), .rstN(rstN), .memFlush(memFlush), .memWr(memWr), .memDisWr(memDisWr),
        .exePc(exePc), .exeAluOut(exeAluOut), .exeOperandB(exeOperandB), .exeDst(exeDst),
        .exeCp0Addr(exeCp0Addr), .exeRegWr(exeRegWr), .exeIsBranch(exeIsBranch),
        .exeInExcValid(exeInExcValid), .exeWbSel(exeWbSel), .exeMemOp(exeMemOp),
        .exeCp0Op(exeCp0Op), .exeInExc(exeInExc), .interrupt(interrupt),
        .memPc(memPc), .memResult(memResult), .memDst(memDst), .memRegWr(memRegWr),
        .dbusValid(dbusValid), .dbusWrite(dbusWrite), .dbusAddr(dbusAddr),
        .dbusWdata(dbusWdata), .dbusWstrb(dbusWstrb), .flushException(flushException),
        .entrySel(entrySel), .exceptionVector(exceptionVector), .cp0Epc(epcOut)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic word_t xorshift();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic stim_t aluInstr(input logic [1:0] wb);
        stim_t s;
        s = '0;
        s.alu = xorshift();
        s.opB = xorshift();
        s.dst = s.alu[12:8];
        s.regWr = 1'b1;
        s.wbSel = wb;
        s.wr = 1'b1;
        return s;
    endfunction

    function automatic stim_t memInstr(input memOp_t op, input logic [1:0] off);
        stim_t s;
        s = aluInstr(wbAluOut);
        s.alu[1:0] = off;
        s.memOp = op;
        s.regWr = (op != memSw && op != memSh && op != memSb);  // loads write back
        return s;
    endfunction

    function automatic stim_t cp0Instr(input cp0Op_t op, input regAddr_t addr, input word_t data);
        stim_t s;
        s = aluInstr((op == cp0OpMfc0) ? 2'(wbOperandB) : 2'(wbAluOut));
        s.cp0Op = op;
        s.cp0Addr = addr;
        s.regWr = (op == cp0OpMfc0);
        if (op == cp0OpMtc0) begin
            s.opB = data;
        end
        return s;
    endfunction

    // one clock edge of the model followed by the combinational response
    task automatic modelStep(input stim_t s, output resp_t r);
        logic [7:0] ip;
        logic       isLoad;
        logic       isStore;
        logic       misaligned;
        logic       detect;
        excCode_t   code;
        word_t      bad;
        word_t      cp0Data;
        int         size;
        if (takeExc) begin
            mExl = 1'b1;
            mExc = takeCode;
            mBd = heldSlot;
            mEpc = heldSlot ? held.pc - 32'd4 : held.pc;
            if (takeCode == excAdel || takeCode == excAdes) begin
                mBadVAddr = takeBad;
            end
        end else if (takeEret) begin
            mExl = 1'b0;
        end else if (doMtc0) begin
            case (held.cp0Addr)
                cp0Status: {mBev, mIm, mExl, mIe} = {held.opB[22], held.opB[15:8], held.opB[1:0]};
                cp0Cause:  mIpSw = held.opB[9:8];
                cp0Epc:    mEpc = held.opB;
                default: ;
            endcase
        end
        mIpHw = s.irq;
        if (s.flush || takeExc) begin  // bubble keeps the old payload
            held.regWr = 1'b0;
            held.wbSel = wbAluOut;
            held.memOp = memNone;
            held.cp0Op = cp0OpNone;
            held.inExcValid = 1'b0;
            heldSlot = 1'b0;
            lastBranch = 1'b0;
        end else if (s.wr) begin
            held = s;
            heldSlot = lastBranch;
            lastBranch = s.isBranch;
        end

        isLoad = held.memOp == memLw || held.memOp == memLh || held.memOp == memLhu
              || held.memOp == memLb || held.memOp == memLbu;
        isStore = held.memOp == memSw || held.memOp == memSh || held.memOp == memSb;
        misaligned = ((held.memOp == memLw || held.memOp == memSw) && held.alu[1:0] != 2'b00)
                  || ((held.memOp == memLh || held.memOp == memLhu || held.memOp == memSh)
                      && held.alu[0]);
        ip = {mIpHw, mIpSw};
        detect = 1'b1;
        code = excInt;
        bad = held.alu;
        if (mIe && !mExl && (ip & mIm) != 8'd0) begin
            code = excInt;
        end else if (held.inExcValid) begin
            code = held.inExc;
            bad = held.pc;
        end else if (misaligned) begin
            code = isStore ? excAdes : excAdel;
        end else begin
            detect = 1'b0;
        end
        takeExc = detect && !s.disWr;
        takeEret = !detect && held.cp0Op == cp0OpEret && !s.disWr;
        doMtc0 = held.cp0Op == cp0OpMtc0 && !s.disWr && !takeExc;
        takeCode = code;
        takeBad = bad;

        case (held.cp0Addr)
            cp0Status: cp0Data = (word_t'(mBev) << 22) | (word_t'(mIm) << 8)
                               | (word_t'(mExl) << 1) | word_t'(mIe);
            cp0Cause:  cp0Data = (word_t'(mBd) << 31) | (word_t'(ip) << 8) | (word_t'(mExc) << 2);
            cp0Epc:    cp0Data = mEpc;
            cp0BadVAddr: cp0Data = mBadVAddr;
            default:   cp0Data = '0;
        endcase
        if (held.wbSel == wbPcPlus8) begin
            r.result = held.pc + 32'd8;
        end else if (held.wbSel == wbAluOut) begin
            r.result = held.alu;
        end else begin
            r.result = (held.cp0Op == cp0OpMfc0) ? cp0Data : held.opB;
        end
        // access size in bytes, a full word when not a narrow store
        size = (held.memOp == memSh) ? 2 : ((held.memOp == memSb) ? 1 : 4);
        for (int b = 0; b < 4; b++) begin
            r.wdata[8 * b +: 8] = held.opB[8 * (b % size) +: 8];  // lane repeats the low bytes
            r.wstrb[b] = isStore && (b / size == held.alu[1:0] / size);
        end
        r.pc = held.pc;
        r.dst = held.dst;
        r.regWr = held.regWr && !takeExc;
        r.valid = (isLoad || isStore) && !takeExc;
        r.write = isStore;
        r.addr = held.alu;
        r.flush = takeExc || takeEret;
        r.entry = takeExc ? entryException : (takeEret ? entryEretReturn : entryNone);
        r.vector = takeEret ? mEpc : (mBev ? vecBoot : vecNormal);
        r.epc = mEpc;
    endtask

    task automatic addRow(input string name, input stim_t s);
        resp_t r;
        s.pc = nextPc;
        s.irq = curIrq;
        nextPc = nextPc + 32'd4;
        modelStep(s, r);
        rows.push_back(s);
        expects.push_back(r);
        names.push_back(name);
    endtask

    task automatic buildTable();
        stim_t s;
        held = 'x;
        held.regWr = 1'b0;
        held.wbSel = wbAluOut;
        held.memOp = memNone;
        held.cp0Op = cp0OpNone;
        held.inExcValid = 1'b0;
        heldSlot = 1'b0;
        lastBranch = 1'b0;
        {mBev, mIm, mExl, mIe} = {resetStatusDefault[22], resetStatusDefault[15:8],
                                  resetStatusDefault[1:0]};
        {mBd, mIpHw, mIpSw, mExc, mEpc, mBadVAddr} = {1'b0, 6'd0, 2'd0, excInt, 32'd0, 32'hx};
        {takeExc, takeEret, doMtc0, takeCode, takeBad} = '0;
        nextPc = 32'hBFC0_1000;
        curIrq = 6'd0;

        addRow("fwd pc+8", aluInstr(wbPcPlus8));
        addRow("fwd aluOut", aluInstr(wbAluOut));
        addRow("fwd operandB", aluInstr(wbOperandB));
        s = aluInstr(wbPcPlus8);
        s.wr = 1'b0;
        addRow("stall holds", s);
        s = aluInstr(wbPcPlus8);
        s.flush = 1'b1;
        addRow("flush bubble", s);

        // every size at every aligned offset
        for (int off = 0; off < 4; off++) begin
            addRow($sformatf("lb off %0d", off), memInstr(memLb, off[1:0]));
            addRow($sformatf("lbu off %0d", off), memInstr(memLbu, off[1:0]));
            addRow($sformatf("sb off %0d", off), memInstr(memSb, off[1:0]));
        end
        for (int off = 0; off < 4; off += 2) begin
            addRow($sformatf("lh off %0d", off), memInstr(memLh, off[1:0]));
            addRow($sformatf("lhu off %0d", off), memInstr(memLhu, off[1:0]));
            addRow($sformatf("sh off %0d", off), memInstr(memSh, off[1:0]));
        end
        addRow("lw aligned", memInstr(memLw, 2'd0));
        addRow("sw aligned", memInstr(memSw, 2'd0));
        addRow("lw misaligned adel", memInstr(memLw, 2'd1));
        addRow("squashed after adel", aluInstr(wbAluOut));
        addRow("mfc0 badvaddr", cp0Instr(cp0OpMfc0, cp0BadVAddr, '0));
        addRow("mfc0 cause adel", cp0Instr(cp0OpMfc0, cp0Cause, '0));
        addRow("sh misaligned ades", memInstr(memSh, 2'd3));
        addRow("squashed after ades", aluInstr(wbAluOut));
        addRow("mfc0 cause ades", cp0Instr(cp0OpMfc0, cp0Cause, '0));

        addRow("mtc0 epc", cp0Instr(cp0OpMtc0, cp0Epc, xorshift()));
        addRow("mfc0 epc", cp0Instr(cp0OpMfc0, cp0Epc, '0));
        s = cp0Instr(cp0OpMtc0, cp0Status, 32'h0000_FF01);
        s.disWr = 1'b1;
        addRow("mtc0 status lost", s);
        addRow("mfc0 status unchanged", cp0Instr(cp0OpMfc0, cp0Status, '0));
        addRow("mtc0 status ie", cp0Instr(cp0OpMtc0, cp0Status, 32'h0000_0001));
        addRow("mfc0 status", cp0Instr(cp0OpMfc0, cp0Status, '0));

        s = aluInstr(wbAluOut);
        s.inExcValid = 1'b1;
        s.inExc = excSys;
        s.disWr = 1'b1;
        addRow("sys held back", s);
        s.wr = 1'b0;   // same sys re-evaluated
        s.disWr = 1'b0;
        addRow("sys normal vector", s);
        addRow("squashed after sys", aluInstr(wbAluOut));
        addRow("mfc0 cause sys", cp0Instr(cp0OpMfc0, cp0Cause, '0));
        addRow("mfc0 epc sys", cp0Instr(cp0OpMfc0, cp0Epc, '0));
        s = aluInstr(wbPcPlus8);
        s.isBranch = 1'b1;
        addRow("branch", s);
        s = aluInstr(wbAluOut);
        s.inExcValid = 1'b1;
        s.inExc = excSys;
        addRow("sys in delay slot", s);
        addRow("squashed after slot sys", aluInstr(wbAluOut));
        addRow("mfc0 cause bd", cp0Instr(cp0OpMfc0, cp0Cause, '0));
        addRow("mfc0 epc branch", cp0Instr(cp0OpMfc0, cp0Epc, '0));
        addRow("eret", cp0Instr(cp0OpEret, '0, '0));

        curIrq = 6'b000001;  // hw line 0 lands on ip bit 2
        addRow("irq masked by im", aluInstr(wbAluOut));
        addRow("mtc0 status im", cp0Instr(cp0OpMtc0, cp0Status, 32'h0000_0401));
        addRow("irq over adel", memInstr(memLw, 2'd2));
        addRow("squashed after irq", aluInstr(wbAluOut));
        addRow("mfc0 cause irq", cp0Instr(cp0OpMfc0, cp0Cause, '0));
        addRow("eret after irq", cp0Instr(cp0OpEret, '0, '0));
        addRow("held irq retaken", aluInstr(wbOperandB));
        addRow("squashed after retake", aluInstr(wbAluOut));
        addRow("mtc0 status ie off", cp0Instr(cp0OpMtc0, cp0Status, 32'h0000_0400));
        addRow("irq masked by ie", aluInstr(wbAluOut));
        curIrq = 6'd0;
        addRow("irq released", aluInstr(wbPcPlus8));
    endtask

    task automatic driveRow(input stim_t s);
        exePc         <= s.pc;
        exeAluOut     <= s.alu;
        exeOperandB   <= s.opB;
        exeDst        <= s.dst;
        exeCp0Addr    <= s.cp0Addr;
        exeRegWr      <= s.regWr;
        exeIsBranch   <= s.isBranch;
        exeInExcValid <= s.inExcValid;
        exeWbSel      <= wbSel_t'(s.wbSel);
        exeMemOp      <= memOp_t'(s.memOp);
        exeCp0Op      <= cp0Op_t'(s.cp0Op);
        exeInExc      <= s.inExc;
        memFlush      <= s.flush;
        memWr         <= s.wr;
        interrupt     <= s.irq;
    endtask

    task automatic checkRow(input int i);
        resp_t got;
        got = {memPc, memResult, memDst, memRegWr, dbusValid, dbusWrite, dbusAddr, dbusWdata,
               dbusWstrb, flushException, entrySel, exceptionVector, epcOut};
        assert (got === expects[i]) begin
            passCount++;
            $display("Pass %s", names[i]);
        end else begin
            failCount++;
            $display("Fail %s expected %h actual %h", names[i], expects[i], got);
        end
    endtask

    initial begin
        stim_t idle;
        idle = '0;
        rstN = 1'b0;
        driveRow(idle);
        memDisWr <= 1'b0;
        buildTable();
        tableReady = 1'b1;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
        // row k is driven at edge k, latched at edge k+1 and checked mid cycle
        for (int k = 0; k <= rows.size(); k++) begin
            @(posedge clk);
            if (k < rows.size()) begin
                driveRow(rows[k]);
            end else begin
                driveRow(idle);
            end
            memDisWr <= (k > 0) ? rows[k - 1].disWr : 1'b0;
            if (k > 0) begin
                @(negedge clk);
                checkRow(k - 1);
            end
        end
        $display("%0d tests, %0d passed, %0d failed", rows.size(), passCount, failCount);
        if (failCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        wait (tableReady);
        #((rows.size() + resetCycles + 10) * clkPeriod);
        $display("watchdog expired before all rows were checked");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== logic/memStage.sv ====
// memory stage top joining the pipeline register, access, exception and cp0 blocks
`timescale 1ns/100ps

module memStage import memPkg::*; #(
    parameter word_t resetStatus = resetStatusDefault
) (
    input  logic       clk,
    input  logic       rstN,
    input  logic       memFlush,
    input  logic       memWr,
    input  logic       memDisWr,
    input  word_t      exePc,
    input  word_t      exeAluOut,
    input  word_t      exeOperandB,
    input  regAddr_t   exeDst,
    input  regAddr_t   exeCp0Addr,
    input  logic       exeRegWr,
    input  logic       exeIsBranch,
    input  logic       exeInExcValid,
    input  wbSel_t     exeWbSel,
    input  memOp_t     exeMemOp,
    input  cp0Op_t     exeCp0Op,
    input  excCode_t   exeInExc,
    input  logic [5:0] interrupt,
    output word_t      memPc,
    output word_t      memResult,
    output regAddr_t   memDst,
    output logic       memRegWr,
    output logic       dbusValid,
    output logic       dbusWrite,
    output word_t      dbusAddr,
    output word_t      dbusWdata,
    output logic [3:0] dbusWstrb,
    output logic       flushException,
    output entrySel_t  entrySel,
    output word_t      exceptionVector,
    output word_t      cp0Epc
);

    memInstrIf  memInstr ();
    cp0StatusIf cp0Status ();

    logic     excTake;
    logic     eretTake;
    excCode_t excCode;
    word_t    badVAddr;
    word_t    cp0RdData;

    assign memPc  = memInstr.pc;
    assign memDst = memInstr.dstReg;  // bypass and refetch use the raw dst

    memStageReg uMemStageReg (
        .clk(clk), .rstN(rstN), .memFlush(memFlush), .memWr(memWr), .excTake(excTake),
        .exePc(exePc), .exeAluOut(exeAluOut), .exeOperandB(exeOperandB),
        .exeDst(exeDst), .exeCp0Addr(exeCp0Addr), .exeRegWr(exeRegWr),
        .exeIsBranch(exeIsBranch), .exeInExcValid(exeInExcValid), .exeWbSel(exeWbSel),
        .exeMemOp(exeMemOp), .exeCp0Op(exeCp0Op), .exeInExc(exeInExc),
        .instr(memInstr.src)
    );

    memAccess uMemAccess (
        .instr(memInstr.dst), .excTake(excTake), .cp0RdData(cp0RdData),
        .memResult(memResult), .memRegWr(memRegWr), .dbusValid(dbusValid),
        .dbusWrite(dbusWrite), .dbusAddr(dbusAddr), .dbusWdata(dbusWdata),
        .dbusWstrb(dbusWstrb)
    );

    exceptionUnit uExceptionUnit (
        .instr(memInstr.dst), .status(cp0Status.exc), .memDisWr(memDisWr),
        .excTake(excTake), .eretTake(eretTake), .flushException(flushException),
        .excCode(excCode), .badVAddr(badVAddr), .entrySel(entrySel),
        .exceptionVector(exceptionVector)
    );

    cp0Regs #(.resetStatus(resetStatus)) uCp0Regs (
        .clk(clk), .rstN(rstN), .memDisWr(memDisWr), .excTake(excTake),
        .eretTake(eretTake), .excCode(excCode), .badVAddr(badVAddr),
        .interrupt(interrupt), .instr(memInstr.dst), .cp0RdData(cp0RdData),
        .cp0Epc(cp0Epc), .status(cp0Status.cp0)
    );

endmodule

// ==== logic/cp0Regs.sv ====
// coprocessor 0 registers with mtc0/mfc0, exception commit, eret and count
`timescale 1ns/100ps

module cp0Regs import memPkg::*; #(
    parameter word_t resetStatus = resetStatusDefault
) (
    input  logic       clk,
    input  logic       rstN,
    input  logic       memDisWr,
    input  logic       excTake,
    input  logic       eretTake,
    input  excCode_t   excCode,
    input  word_t      badVAddr,
    input  logic [5:0] interrupt,
    memInstrIf.dst     instr,
    output word_t      cp0RdData,
    output word_t      cp0Epc,
    cp0StatusIf.cp0    status
);

    word_t      statusQ;
    word_t      epcQ;
    word_t      badVAddrQ;
    word_t      countQ;
    logic       causeBd;
    logic [5:0] causeIpHw;
    logic [1:0] causeIpSw;
    excCode_t   causeExc;
    word_t      causeWord;
    logic       mtc0Wr;

    // no write while stalled or when the instruction is cancelled
    assign mtc0Wr = (instr.cp0Op == cp0OpMtc0) && !memDisWr && !excTake;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            statusQ <= resetStatus;
        end else if (excTake) begin
            statusQ[statusExlBit] <= 1'b1;
        end else if (eretTake) begin
            statusQ[statusExlBit] <= 1'b0;
        end else if (mtc0Wr && instr.cp0Addr == cp0Status) begin
            statusQ <= (statusQ & ~statusWrMask) | (instr.operandB & statusWrMask);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            causeBd   <= 1'b0;
            causeIpHw <= 6'd0;
            causeIpSw <= 2'd0;
            causeExc  <= excInt;
        end else begin
            causeIpHw <= interrupt;  // sampled every cycle
            if (excTake) begin
                causeBd  <= instr.inDelaySlot;
                causeExc <= excCode;
            end else if (mtc0Wr && instr.cp0Addr == cp0Cause) begin
                causeIpSw <= instr.operandB[9:8];  // software interrupts only
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            epcQ <= '0;
        end else if (excTake) begin
            epcQ <= instr.inDelaySlot ? instr.pc - 32'd4 : instr.pc;  // restart at the branch
        end else if (mtc0Wr && instr.cp0Addr == memPkg::cp0Epc) begin
            epcQ <= instr.operandB;
        end
    end

    always_ff @(posedge clk) begin
        if (excTake && (excCode == excAdel || excCode == excAdes)) begin
            badVAddrQ <= badVAddr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            countQ <= '0;
        end else if (mtc0Wr && instr.cp0Addr == cp0Count) begin
            countQ <= instr.operandB;
        end else begin
            countQ <= countQ + 32'd1;
        end
    end

    assign causeWord = {causeBd, 15'd0, causeIpHw, causeIpSw, 1'b0, causeExc, 2'b00};

    always_comb begin
        case (instr.cp0Addr)
            cp0BadVAddr:    cp0RdData = badVAddrQ;
            cp0Count:       cp0RdData = countQ;
            cp0Status:      cp0RdData = statusQ;
            cp0Cause:       cp0RdData = causeWord;
            memPkg::cp0Epc: cp0RdData = epcQ;
            default:        cp0RdData = '0;  // unimplemented reads as zero
        endcase
    end

    assign status.bev = statusQ[statusBevBit];
    assign status.exl = statusQ[statusExlBit];
    assign status.ie  = statusQ[statusIeBit];
    assign status.im  = statusQ[15:8];
    assign status.ip  = {causeIpHw, causeIpSw};
    assign status.epc = epcQ;
    assign cp0Epc     = epcQ;

endmodule

// ==== logic/exceptionUnit.sv ====
// exception and interrupt priority, redirect vector and pipeline flush
`timescale 1ns/100ps

module exceptionUnit import memPkg::*; (
    memInstrIf.dst    instr,
    cp0StatusIf.exc   status,
    input  logic      memDisWr,
    output logic      excTake,
    output logic      eretTake,
    output logic      flushException,
    output excCode_t  excCode,
    output word_t     badVAddr,
    output entrySel_t entrySel,
    output word_t     exceptionVector
);

    logic intPending;
    logic addrErrLoad;
    logic addrErrStore;
    logic excDetect;

    // interrupts are masked while exl is set
    assign intPending = status.ie && !status.exl && |(status.ip & status.im);

    always_comb begin
        addrErrLoad  = 1'b0;
        addrErrStore = 1'b0;
        case (instr.memOp)
            memLw:        addrErrLoad  = |instr.aluOut[1:0];
            memLh, memLhu: addrErrLoad = instr.aluOut[0];
            memSw:        addrErrStore = |instr.aluOut[1:0];
            memSh:        addrErrStore = instr.aluOut[0];
            default: ;
        endcase
    end

    // highest priority first
    always_comb begin
        excDetect = 1'b1;
        excCode   = excInt;
        badVAddr  = instr.aluOut;
        if (intPending) begin
            excCode = excInt;
        end else if (instr.inExcValid) begin
            excCode  = instr.inExc;
            badVAddr = instr.pc;  // fetch side address error
        end else if (addrErrLoad) begin
            excCode = excAdel;
        end else if (addrErrStore) begin
            excCode = excAdes;
        end else begin
            excDetect = 1'b0;
        end
    end

    assign excTake        = excDetect && !memDisWr;
    assign eretTake       = !excDetect && (instr.cp0Op == cp0OpEret) && !memDisWr;
    assign flushException = excTake || eretTake;

    always_comb begin
        if (excTake) begin
            entrySel = entryException;
        end else if (eretTake) begin
            entrySel = entryEretReturn;
        end else begin
            entrySel = entryNone;
        end
    end

    // epc for eret, otherwise the bev selected vector
    always_comb begin
        if (eretTake) begin
            exceptionVector = status.epc;
        end else begin
            exceptionVector = status.bev ? vecBoot : vecNormal;
        end
    end

endmodule

// ==== logic/memAccess.sv ====
// data cache request forming and forwarding result select
`timescale 1ns/100ps

module memAccess import memPkg::*; (
    memInstrIf.dst     instr,
    input  logic       excTake,
    input  word_t      cp0RdData,
    output word_t      memResult,
    output logic       memRegWr,
    output logic       dbusValid,
    output logic       dbusWrite,
    output word_t      dbusAddr,
    output word_t      dbusWdata,
    output logic [3:0] dbusWstrb
);

    logic isLoad;
    logic isStore;

    assign isLoad  = instr.memOp inside {memLw, memLh, memLhu, memLb, memLbu};
    assign isStore = instr.memOp inside {memSw, memSh, memSb};

    assign dbusValid = (isLoad || isStore) && !excTake;  // cancelled access never issues
    assign dbusWrite = isStore;
    assign dbusAddr  = instr.aluOut;
    assign memRegWr  = instr.regWr && !excTake;

    // byte lanes from size and low address bits
    always_comb begin
        dbusWstrb = 4'b0000;
        dbusWdata = instr.operandB;
        case (instr.memOp)
            memSw: dbusWstrb = 4'b1111;
            memSh: begin
                dbusWstrb = instr.aluOut[1] ? 4'b1100 : 4'b0011;
                dbusWdata = {2{instr.operandB[15:0]}};
            end
            memSb: begin
                dbusWstrb = 4'b0001 << instr.aluOut[1:0];
                dbusWdata = {4{instr.operandB[7:0]}};
            end
            default: ;
        endcase
    end

    always_comb begin
        case (instr.wbSel)
            wbPcPlus8: memResult = instr.pc + 32'd8;  // link address
            wbAluOut:  memResult = instr.aluOut;
            default:   memResult = (instr.cp0Op == cp0OpMfc0) ? cp0RdData : instr.operandB;
        endcase
    end

endmodule

// ==== logic/memStageReg.sv ====
// execute to memory pipeline register with stall, flush and delay slot tracking
`timescale 1ns/100ps

module memStageReg import memPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     memFlush,
    input  logic     memWr,
    input  logic     excTake,
    input  word_t    exePc,
    input  word_t    exeAluOut,
    input  word_t    exeOperandB,
    input  regAddr_t exeDst,
    input  regAddr_t exeCp0Addr,
    input  logic     exeRegWr,
    input  logic     exeIsBranch,
    input  logic     exeInExcValid,
    input  wbSel_t   exeWbSel,
    input  memOp_t   exeMemOp,
    input  cp0Op_t   exeCp0Op,
    input  excCode_t exeInExc,
    memInstrIf.src   instr
);

    logic lastBranch;  // the instruction now in mem is a branch
    logic bubble;

    assign bubble = memFlush || excTake;

    // control fields
    always_ff @(posedge clk) begin
        if (!rstN) begin
            instr.regWr       <= 1'b0;
            instr.wbSel       <= wbAluOut;
            instr.memOp       <= memNone;
            instr.cp0Op       <= cp0OpNone;
            instr.inExcValid  <= 1'b0;
            instr.inDelaySlot <= 1'b0;
            lastBranch        <= 1'b0;
        end else if (bubble) begin
            instr.regWr       <= 1'b0;
            instr.wbSel       <= wbAluOut;
            instr.memOp       <= memNone;
            instr.cp0Op       <= cp0OpNone;
            instr.inExcValid  <= 1'b0;
            instr.inDelaySlot <= 1'b0;
            lastBranch        <= 1'b0;
        end else if (memWr) begin
            instr.regWr       <= exeRegWr;
            instr.wbSel       <= exeWbSel;
            instr.memOp       <= exeMemOp;
            instr.cp0Op       <= exeCp0Op;
            instr.inExcValid  <= exeInExcValid;
            instr.inDelaySlot <= lastBranch;  // follows a branch
            lastBranch        <= exeIsBranch;
        end
    end

    // payload is only meaningful under valid controls
    always_ff @(posedge clk) begin
        if (memWr && !bubble) begin
            instr.pc       <= exePc;
            instr.aluOut   <= exeAluOut;
            instr.operandB <= exeOperandB;
            instr.dstReg   <= exeDst;
            instr.cp0Addr  <= exeCp0Addr;
            instr.inExc    <= exeInExc;
        end
    end

endmodule

// ==== logic/memIfc.sv ====
// memory stage interfaces for the latched instruction and the cp0 status view
`timescale 1ns/100ps

interface memInstrIf import memPkg::*; ();
    word_t    pc;
    word_t    aluOut;      // also the data address
    word_t    operandB;    // store data, mtc0 data, hi/lo or rt value
    regAddr_t dstReg;
    logic     regWr;
    wbSel_t   wbSel;
    memOp_t   memOp;
    cp0Op_t   cp0Op;
    regAddr_t cp0Addr;
    excCode_t inExc;       // code raised before memory
    logic     inExcValid;
    logic     inDelaySlot;

    modport src (
        output pc, aluOut, operandB, dstReg, regWr, wbSel, memOp, cp0Op, cp0Addr,
               inExc, inExcValid, inDelaySlot
    );

    modport dst (
        input pc, aluOut, operandB, dstReg, regWr, wbSel, memOp, cp0Op, cp0Addr,
              inExc, inExcValid, inDelaySlot
    );
endinterface

interface cp0StatusIf import memPkg::*; ();
    logic       bev;
    logic       exl;
    logic       ie;
    logic [7:0] im;
    logic [7:0] ip;   // hw 7..2, sw 1..0
    word_t      epc;

    modport cp0 (output bev, exl, ie, im, ip, epc);

    modport exc (input bev, exl, ie, im, ip, epc);
endinterface

// ==== logic/memPkg.sv ====
// memory stage package with word types, operation enums and cp0 constants
package memPkg;

    typedef logic [31:0] word_t;     // data or address word
    typedef logic [4:0]  regAddr_t;  // gpr destination or cp0 register number
    typedef logic [4:0]  excCode_t;  // cause.ExcCode encoding

    typedef enum logic [3:0] {
        memNone,
        memLw,
        memLh,
        memLhu,
        memLb,
        memLbu,
        memSw,
        memSh,
        memSb
    } memOp_t;

    // source of the result forwarded back to execute
    typedef enum logic [1:0] {
        wbPcPlus8,
        wbAluOut,
        wbOperandB
    } wbSel_t;

    typedef enum logic [1:0] {
        cp0OpNone,
        cp0OpMfc0,
        cp0OpMtc0,
        cp0OpEret
    } cp0Op_t;

    typedef enum logic [1:0] {
        entryNone,
        entryException,
        entryEretReturn
    } entrySel_t;

    localparam excCode_t excInt  = 5'd0;
    localparam excCode_t excAdel = 5'd4;
    localparam excCode_t excAdes = 5'd5;
    localparam excCode_t excSys  = 5'd8;
    localparam excCode_t excBp   = 5'd9;
    localparam excCode_t excRi   = 5'd10;

    localparam regAddr_t cp0BadVAddr = 5'd8;
    localparam regAddr_t cp0Count    = 5'd9;
    localparam regAddr_t cp0Status   = 5'd12;
    localparam regAddr_t cp0Cause    = 5'd13;
    localparam regAddr_t cp0Epc      = 5'd14;

    localparam word_t vecBoot   = 32'hBFC0_0380;  // BEV set
    localparam word_t vecNormal = 32'h8000_0180;

    // status fields, BEV / IM / EXL / IE are writable by mtc0
    localparam int    statusBevBit  = 22;
    localparam int    statusExlBit  = 1;
    localparam int    statusIeBit   = 0;
    localparam word_t statusWrMask  = 32'h0040_FF03;

    localparam word_t resetStatusDefault = 32'h0040_0000;  // boot vectors after reset

endpackage
